//--- stream_source_pkg.sv
// stream source shared widths, port count, vector types and control FSM states
package stream_source_pkg;

  // memory side
  localparam int unsigned NB_PORTS = 2;          // tcdm ports per wide word
  localparam int unsigned WORD_W   = 32;         // one port word
  localparam int unsigned ADDR_W   = 32;         // byte address

  // stream side
  localparam int unsigned DATA_W = NB_PORTS * WORD_W;

  // counters for beats and lines
  localparam int unsigned CNT_W = 16;

  // byte distance between consecutive wide words
  localparam int unsigned STEP = NB_PORTS * 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [CNT_W-1:0]  cnt_t;

  // control FSM
  // idle waits for start, working issues requests until the last grant
  typedef enum logic {
    SRC_IDLE,
    SRC_WORKING
  } src_state_e;

endpackage

//--- tcdm_addr_gen.sv
// two-dimensional address generator, lines of consecutive wide words with a stride
`timescale 1ns/10ps

module tcdm_addr_gen
  import stream_source_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  enable_i,
  input  addr_t base_addr_i,
  input  cnt_t  trans_size_i,
  input  cnt_t  line_length_i,
  input  addr_t line_stride_i,
  output addr_t addr_o,
  output logic  in_progress_o
);

  cnt_t  word_idx_q;   // word within current line
  addr_t line_base_q;  // offset of current line start
  cnt_t  beat_cnt_q;   // beats already granted

  cnt_t  line_last;
  cnt_t  beat_last;
  addr_t word_off;

  assign line_last = cnt_t'(line_length_i - 1'b1);
  assign beat_last = cnt_t'(trans_size_i - 1'b1);
  assign word_off  = addr_t'(addr_t'(word_idx_q) * STEP);

  assign addr_o        = base_addr_i + line_base_q + word_off;
  assign in_progress_o = (beat_cnt_q < beat_last);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_idx_q  <= '0;
      line_base_q <= '0;
      beat_cnt_q  <= '0;
    end else if (clear_i) begin
      word_idx_q  <= '0;
      line_base_q <= '0;
      beat_cnt_q  <= '0;
    end else if (enable_i) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
      if (word_idx_q == line_last) begin
        // end of line, jump to next line start
        word_idx_q  <= '0;
        line_base_q <= line_base_q + line_stride_i;
      end else begin
        word_idx_q <= word_idx_q + 1'b1;
      end
    end
  end

  // a zero line length would never wrap the word index
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    enable_i |-> (line_length_i != '0))
    else $error("line_length_i is zero while the address generator runs");

endmodule

//--- tcdm_port_buf.sv
// per-port response buffer, holds a returned word until the merged stream takes it
`timescale 1ns/10ps

module tcdm_port_buf
  import stream_source_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  r_valid_i,
  input  word_t r_data_i,
  input  logic  ready_i,
  output logic  valid_o,
  output word_t data_o
);

  logic  valid_q;
  word_t data_q;

  // held word has priority, it is the older one
  assign valid_o = r_valid_i | valid_q;
  assign data_o  = valid_q ? data_q : r_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
    end else if (r_valid_i && !ready_i) begin
      valid_q <= 1'b1;                 // stream stalled, keep it
    end else if (valid_q && ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_valid_i && !ready_i) begin
      data_q <= r_data_i;
    end
  end

  // requests stop while the stream stalls, so a held word never meets a new response
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_q |-> !r_valid_i)
    else $error("response arrived while a held word was still pending");

endmodule

//--- stream_lane_merge.sv
// joins the per-port lanes into one wide stream beat, all lanes move together
`timescale 1ns/10ps

module stream_lane_merge
  import stream_source_pkg::*;
(
  input  logic [NB_PORTS-1:0] lane_valid_i,
  input  word_t [NB_PORTS-1:0] lane_data_i,
  output logic [NB_PORTS-1:0] lane_ready_o,
  input  logic                stream_ready_i,
  output logic                stream_valid_o,
  output data_t               stream_data_o
);

  assign stream_valid_o = &lane_valid_i;

  always_comb begin
    for (int i = 0; i < NB_PORTS; i++) begin
      stream_data_o[i*WORD_W +: WORD_W] = lane_data_i[i];  // port 0 in low word
    end
  end

  // a lane is popped only when every other lane is there too
  always_comb begin
    for (int i = 0; i < NB_PORTS; i++) begin
      lane_ready_o[i] = stream_ready_i;
      for (int j = 0; j < NB_PORTS; j++) begin
        if (j != i) begin
          lane_ready_o[i] = lane_ready_o[i] & lane_valid_i[j];
        end
      end
    end
  end

endmodule

//--- stream_source.sv
// stream source top that reads a 2d block over the tcdm ports and emits it as a wide stream
`timescale 1ns/10ps

module stream_source
  import stream_source_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  addr_t                base_addr_i,
  input  cnt_t                 trans_size_i,
  input  cnt_t                 line_length_i,
  input  addr_t                line_stride_i,
  output logic                 ready_start_o,
  output logic                 done_o,
  output logic [NB_PORTS-1:0]  tcdm_req_o,
  output addr_t [NB_PORTS-1:0] tcdm_add_o,
  input  logic [NB_PORTS-1:0]  tcdm_gnt_i,
  input  logic [NB_PORTS-1:0]  tcdm_r_valid_i,
  input  word_t [NB_PORTS-1:0] tcdm_r_data_i,
  output logic                 stream_valid_o,
  output data_t                stream_data_o,
  input  logic                 stream_ready_i
);

  src_state_e cs, ns;

  logic  int_req;
  logic  all_gnt;
  logic  beat_gnt;       // every port granted this cycle
  logic  last_gnt;
  logic  ag_en;
  logic  ag_clr;
  logic  in_progress;
  addr_t gen_addr;
  logic  done_q;
  logic  rsp_pend_q;     // a response is due this cycle

  logic [NB_PORTS-1:0]  lane_valid;
  word_t [NB_PORTS-1:0] lane_data;
  logic [NB_PORTS-1:0]  lane_ready;

  assign all_gnt  = &tcdm_gnt_i;
  assign beat_gnt = int_req & all_gnt;
  assign ag_clr   = clear_i | last_gnt;  // rewind for the next transfer

  tcdm_addr_gen i_addr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .clear_i       ( ag_clr        ),
    .enable_i      ( ag_en         ),
    .base_addr_i   ( base_addr_i   ),
    .trans_size_i  ( trans_size_i  ),
    .line_length_i ( line_length_i ),
    .line_stride_i ( line_stride_i ),
    .addr_o        ( gen_addr      ),
    .in_progress_o ( in_progress   )
  );

  for (genvar i = 0; i < NB_PORTS; i++) begin : gen_port
    assign tcdm_req_o[i] = int_req;
    assign tcdm_add_o[i] = addr_t'(gen_addr + addr_t'(4 * i));

    tcdm_port_buf i_port_buf (
      .clk_i     ( clk_i                           ),
      .rst_ni    ( rst_ni                          ),
      .clear_i   ( clear_i                         ),
      .r_valid_i ( tcdm_r_valid_i[i] & rsp_pend_q  ),
      .r_data_i  ( tcdm_r_data_i[i]                ),
      .ready_i   ( lane_ready[i]                   ),
      .valid_o   ( lane_valid[i]                   ),
      .data_o    ( lane_data[i]                    )
    );
  end

  stream_lane_merge i_lane_merge (
    .lane_valid_i   ( lane_valid     ),
    .lane_data_i    ( lane_data      ),
    .lane_ready_o   ( lane_ready     ),
    .stream_ready_i ( stream_ready_i ),
    .stream_valid_o ( stream_valid_o ),
    .stream_data_o  ( stream_data_o  )
  );

  always_comb begin
    ns            = cs;
    int_req       = 1'b0;
    ag_en         = 1'b0;
    last_gnt      = 1'b0;
    ready_start_o = 1'b0;
    case (cs)
      SRC_IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) begin
          ns = SRC_WORKING;
        end
      end
      SRC_WORKING: begin
        int_req = stream_ready_i;  // no requests under back-pressure
        if (beat_gnt) begin
          ag_en = 1'b1;
          if (!in_progress) begin
            last_gnt = 1'b1;
            ns       = SRC_IDLE;
          end
        end
      end
      default: ns = SRC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs         <= SRC_IDLE;
      done_q     <= 1'b0;
      rsp_pend_q <= 1'b0;
    end else if (clear_i) begin
      cs         <= SRC_IDLE;
      done_q     <= 1'b0;
      rsp_pend_q <= 1'b0;   // drops a response still in flight
    end else begin
      cs         <= ns;
      done_q     <= last_gnt;
      rsp_pend_q <= beat_gnt;
    end
  end

  assign done_o = done_q;

  // every port answers one cycle after a beat grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_pend_q |-> (&tcdm_r_valid_i))
    else $error("tcdm response missing one cycle after a grant");

  // an empty transfer would run until the beat counter wraps
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_i && cs == SRC_IDLE) |-> (trans_size_i != '0))
    else $error("start with zero trans_size_i");

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset source, 8 ns period with reset held for 8 cycles
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1;
    rst_no = 1'b1;  // released just after an edge
  end

endmodule

//--- tb_tcdm_mem.sv
// testbench tcdm model, joint grants with random stalls and one-cycle read latency
`timescale 1ns/10ps

module tb_tcdm_mem
  import stream_source_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 stall_en_i,
  input  logic [NB_PORTS-1:0]  req_i,
  input  addr_t [NB_PORTS-1:0] add_i,
  output logic [NB_PORTS-1:0]  gnt_o,
  output logic [NB_PORTS-1:0]  r_valid_o,
  output word_t [NB_PORTS-1:0] r_data_o
);

  int   seed = 32'h3bbe;
  logic gnt_q;

  // content of the word at byte address a
  function automatic word_t mem_word(input addr_t a);
    return a ^ 32'h5a5a_0000;
  endfunction

  assign gnt_o = {NB_PORTS{gnt_q}};  // all ports together

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q     <= 1'b1;
      r_valid_o <= '0;
      r_data_o  <= '0;
    end else begin
      if (stall_en_i) begin
        gnt_q <= (($random(seed) & 3) != 0);  // about one stall in four
      end else begin
        gnt_q <= 1'b1;
      end
      for (int unsigned i = 0; i < NB_PORTS; i++) begin
        r_valid_o[i] <= req_i[i] & gnt_o[i];
        r_data_o[i]  <= mem_word(add_i[i]);
      end
    end
  end

endmodule

//--- tb_stream_source.sv
// testbench for the stream source that checks a table of transfers beat by beat
`timescale 1ns/10ps

module tb_stream_source
  import stream_source_pkg::*;
;

  typedef struct packed {
    addr_t      base;
    cnt_t       size;
    cnt_t       line_len;
    addr_t      stride;
    logic       stall;      // random grant stalls
    logic [6:0] ready_pct;  // consumer ready probability
    logic       mid_clear;
  } test_row_t;

  localparam int unsigned NB_TESTS = 7;
  localparam test_row_t TESTS [NB_TESTS] = '{
    '{32'h0000_1000, 16'd8,  16'd8, 32'h0000_0000, 1'b0, 7'd100, 1'b0},  // linear
    '{32'h0000_2000, 16'd12, 16'd3, 32'h0000_0040, 1'b0, 7'd100, 1'b0},  // 2d
    '{32'h0000_3010, 16'd16, 16'd4, 32'h0000_0100, 1'b0, 7'd50,  1'b0},
    '{32'h0000_4000, 16'd16, 16'd5, 32'h0000_0030, 1'b1, 7'd100, 1'b0},
    '{32'h0000_5008, 16'd20, 16'd6, 32'h0000_0080, 1'b1, 7'd60,  1'b0},
    '{32'h0000_6000, 16'd12, 16'd4, 32'h0000_0020, 1'b1, 7'd70,  1'b1},  // clear mid-way
    '{32'h0000_7000, 16'd1,  16'd1, 32'h0000_0000, 1'b0, 7'd100, 1'b0}   // single beat
  };

  logic clk, rst_n;
  logic clear, start, ready_start, done, stall_en;
  addr_t base_addr, line_stride;
  cnt_t  trans_size, line_length;
  logic [NB_PORTS-1:0]  tcdm_req, tcdm_gnt, tcdm_r_valid;
  addr_t [NB_PORTS-1:0] tcdm_add;
  word_t [NB_PORTS-1:0] tcdm_r_data;
  logic  stream_valid, stream_ready;
  data_t stream_data;

  test_row_t   cur_row = TESTS[0];
  int          ready_seed = 32'h3bbe;
  int unsigned beat_idx = 0;
  int unsigned done_cnt = 0;
  int unsigned err_cnt = 0;
  int unsigned pass_cnt = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  tb_tcdm_mem i_tcdm_mem (
    .clk_i(clk), .rst_ni(rst_n), .stall_en_i(stall_en), .req_i(tcdm_req), .add_i(tcdm_add),
    .gnt_o(tcdm_gnt), .r_valid_o(tcdm_r_valid), .r_data_o(tcdm_r_data)
  );

  stream_source i_stream_source (
    .clk_i(clk), .rst_ni(rst_n), .clear_i(clear), .start_i(start),
    .base_addr_i(base_addr), .trans_size_i(trans_size), .line_length_i(line_length),
    .line_stride_i(line_stride), .ready_start_o(ready_start), .done_o(done),
    .tcdm_req_o(tcdm_req), .tcdm_add_o(tcdm_add), .tcdm_gnt_i(tcdm_gnt),
    .tcdm_r_valid_i(tcdm_r_valid), .tcdm_r_data_i(tcdm_r_data),
    .stream_valid_o(stream_valid), .stream_data_o(stream_data), .stream_ready_i(stream_ready)
  );

  task automatic check_val(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // beat k is word k % line_len of line k / line_len
  function automatic data_t expected_beat(input test_row_t r, input int unsigned k);
    int unsigned line;
    int unsigned col;
    addr_t       a;
    data_t       d;
    line = k / 32'(r.line_len);
    col  = k % 32'(r.line_len);
    a    = r.base + addr_t'(line) * r.stride + addr_t'(col * STEP);
    for (int unsigned i = 0; i < NB_PORTS; i++) begin
      d[i*WORD_W +: WORD_W] = (a + addr_t'(4 * i)) ^ 32'h5a5a_0000;
    end
    return d;
  endfunction

  task automatic start_transfer(input test_row_t r);
    @(posedge clk);
    #1;
    cur_row     = r;
    base_addr   = r.base;
    trans_size  = r.size;
    line_length = r.line_len;
    line_stride = r.stride;
    stall_en    = r.stall;
    start       = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_beats(input int unsigned target, input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (beat_idx < target && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (beat_idx < target) begin
      $display("only %0d of %0d beats arrived within %0d cycles", beat_idx, target, max_cycles);
      err_cnt++;
    end
  endtask

  task automatic wait_done(input int unsigned max_cycles);
    int unsigned n;
    n = 0;
    while (done_cnt == 0 && n < max_cycles) begin
      @(negedge clk);
      n++;
    end
    if (done_cnt == 0) begin
      $display("no done_o pulse within %0d cycles", max_cycles);
      err_cnt++;
    end
  endtask

  task automatic run_test(input test_row_t r);
    @(negedge clk);
    check_val("ready_start_o", data_t'(ready_start), data_t'(1'b1));
    start_transfer(r);
    if (r.mid_clear) begin
      wait_beats(32'(r.size) / 2, 32'(r.size) * 20);
      @(posedge clk);
      #1;
      clear = 1'b1;
      @(posedge clk);
      #1;
      clear = 1'b0;
      @(negedge clk);
      check_val("stream_valid_o", data_t'(stream_valid), '0);
      check_val("tcdm_req_o", data_t'(tcdm_req), '0);
      check_val("ready_start_o", data_t'(ready_start), data_t'(1'b1));
      start_transfer(r);  // same block again from the start
    end
    wait_done(32'(r.size) * 20);
    wait_beats(32'(r.size), 32'(r.size) * 20);
    repeat (4) @(negedge clk);  // catch a late extra beat or done
    check_val("done_o pulses", data_t'(done_cnt), data_t'(1));
    check_val("accepted beats", data_t'(beat_idx), data_t'(r.size));
    check_val("ready_start_o", data_t'(ready_start), data_t'(1'b1));
  endtask

  // consumer ready redrawn every cycle
  initial begin
    int unsigned draw;
    stream_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      draw = $unsigned($random(ready_seed)) % 32'd100;
      stream_ready = (draw < 32'(cur_row.ready_pct));
    end
  end

  // monitor that restarts its counters while start is high
  initial begin
    forever begin
      @(negedge clk);
      if (start) begin
        beat_idx = 0;
        done_cnt = 0;
      end else if (rst_n) begin
        if (done) begin
          // last beat shows up with done or later
          check_val("beats before done_o", data_t'(beat_idx < 32'(cur_row.size)), data_t'(1'b1));
          done_cnt++;
        end
        if (stream_valid && stream_ready) begin
          check_val("stream_data_o", stream_data, expected_beat(cur_row, beat_idx));
          beat_idx++;
        end
      end
    end
  end

  initial begin
    int unsigned limit;
    limit = 200;
    for (int unsigned t = 0; t < NB_TESTS; t++) begin
      limit += 32'(TESTS[t].size) * 20 * (TESTS[t].mid_clear ? 2 : 1);
    end
    repeat (limit + 8) @(posedge clk);
    $display("run stopped after %0d cycles without finishing", limit + 8);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int unsigned err_start;
    clear       = 1'b0;
    start       = 1'b0;
    stall_en    = 1'b0;
    base_addr   = '0;
    trans_size  = '0;
    line_length = '0;
    line_stride = '0;
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    for (int unsigned t = 0; t < NB_TESTS; t++) begin
      err_start = err_cnt;
      run_test(TESTS[t]);
      $write("test %0d base %h size %0d line %0d stride %h ", t, TESTS[t].base,
             TESTS[t].size, TESTS[t].line_len, TESTS[t].stride);
      $display("stall %0b ready %0d clear %0b: %0d beats, %0d errors", TESTS[t].stall,
               TESTS[t].ready_pct, TESTS[t].mid_clear, beat_idx, err_cnt - err_start);
    end
    $display("%0d tests, %0d checks passed, %0d errors", NB_TESTS, pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- stream_source.f
stream_source_pkg.sv
tcdm_addr_gen.sv
tcdm_port_buf.sv
stream_lane_merge.sv
stream_source.sv
tb_clk_gen.sv
tb_tcdm_mem.sv
tb_stream_source.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the stream source testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f stream_source.f \
  --top-module tb_stream_source -o sim_stream_source

out="$(./obj_dir/sim_stream_source)"
echo "$out"

if grep -qx "Verification passed" <<< "$out"; then
  exit 0
fi
exit 1
